/* pmem_subsystem.f */
rtl/pmem_pkg.sv
rtl/pmem_arbiter.sv
rtl/cacheline_adaptor.sv
rtl/pmem_subsystem.sv
verification/burst_mem_model.sv
verification/tb_pmem_subsystem.sv

/* rtl/cacheline_adaptor.sv */
`timescale 1ns/1ns

module cacheline_adaptor (
	input  logic            i_clk,
	input  logic            i_arst_n,

	// Line side, from the arbiter.
	input  logic            i_line_read,
	input  logic            i_line_write,
	input  pmem_pkg::addr_t i_line_addr,
	input  pmem_pkg::line_t i_line_wdata,
	output logic            o_line_resp,
	output pmem_pkg::line_t o_line_rdata,

	// Burst memory bus.
	output logic            o_burst_read,
	output logic            o_burst_write,
	output pmem_pkg::addr_t o_burst_addr,
	output pmem_pkg::beat_t o_burst_wdata,
	input  logic            i_burst_resp,
	input  pmem_pkg::beat_t i_burst_rdata
);

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		BURST = 2'b01,
		DONE  = 2'b10
	} state_e;

	state_e                         state;
	logic [pmem_pkg::BEAT_CNT_W-1:0] beat_cnt;
	logic                           last_beat;
	logic                           start;
	logic                           is_write;
	pmem_pkg::addr_t                base_addr;
	pmem_pkg::line_t                line_buf;

	assign start     = (state == IDLE) && (i_line_read || i_line_write);
	assign last_beat = int'(beat_cnt) == (pmem_pkg::BURSTS - 1);

	// ============================================================
	// Control.
	// ============================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					beat_cnt <= '0;
					if (start)
						state <= BURST;
				end
				BURST: begin
					if (i_burst_resp) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat)
							state <= DONE;
					end
				end
				// Response cycle while the client still holds its request.
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// Line buffer.
	// ============================================================

	always_ff @(posedge i_clk) begin
		if (start) begin
			is_write  <= i_line_write;
			base_addr <= {i_line_addr[pmem_pkg::ADDR_W-1:pmem_pkg::LINE_OFFS_W],
				{pmem_pkg::LINE_OFFS_W{1'b0}}};
			line_buf  <= i_line_wdata;
		end else if ((state == BURST) && i_burst_resp) begin
			if (is_write) begin
				line_buf <= line_buf >> pmem_pkg::BEAT_W; // Next beat to the bottom.
			end else begin
				// Beats enter at the top so beat 0 ends lowest.
				line_buf <= {i_burst_rdata, line_buf[pmem_pkg::LINE_W-1:pmem_pkg::BEAT_W]};
			end
		end
	end

	assign o_burst_read  = (state == BURST) && !is_write;
	assign o_burst_write = (state == BURST) && is_write;
	assign o_burst_addr  = base_addr +
		pmem_pkg::addr_t'(beat_cnt) * pmem_pkg::addr_t'(pmem_pkg::BEAT_BYTES);
	assign o_burst_wdata = line_buf[pmem_pkg::BEAT_W-1:0];

	assign o_line_resp  = (state == DONE);
	assign o_line_rdata = line_buf;

	// Memory must not answer a beat that was never requested.
	a_resp_in_burst: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_burst_resp |-> (o_burst_read || o_burst_write));

endmodule : cacheline_adaptor

/* rtl/pmem_arbiter.sv */
`timescale 1ns/1ns

module pmem_arbiter (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic            i_iq_empty,

	// Instruction cache side.
	input  logic            i_inst_read,
	input  logic            i_inst_write,
	input  pmem_pkg::addr_t i_inst_addr,
	input  pmem_pkg::line_t i_inst_wdata,
	output logic            o_inst_resp,
	output pmem_pkg::line_t o_inst_rdata,

	// Load/store cache side.
	input  logic            i_lsq_read,
	input  logic            i_lsq_write,
	input  pmem_pkg::addr_t i_lsq_addr,
	input  pmem_pkg::line_t i_lsq_wdata,
	output logic            o_lsq_resp,
	output pmem_pkg::line_t o_lsq_rdata,

	// Toward the cacheline adaptor.
	output logic            o_line_read,
	output logic            o_line_write,
	output pmem_pkg::addr_t o_line_addr,
	output pmem_pkg::line_t o_line_wdata,
	input  logic            i_line_resp,
	input  pmem_pkg::line_t i_line_rdata
);

	pmem_pkg::owner_e owner_q;
	pmem_pkg::owner_e owner_new;
	pmem_pkg::owner_e owner_sel;
	logic             inst_req;
	logic             lsq_req;
	logic             new_req;

	assign inst_req = i_inst_read || i_inst_write;
	assign lsq_req  = i_lsq_read || i_lsq_write;

	// Lsq wins unless the instruction queue ran dry.
	always_comb begin
		if (i_iq_empty) begin
			owner_new = pmem_pkg::OWN_INST;
		end else if (lsq_req) begin
			owner_new = pmem_pkg::OWN_LSQ;
		end else if (inst_req) begin
			owner_new = pmem_pkg::OWN_INST;
		end else begin
			owner_new = pmem_pkg::OWN_NONE;
		end
	end

	assign new_req = ((owner_new == pmem_pkg::OWN_INST) && inst_req) ||
		((owner_new == pmem_pkg::OWN_LSQ) && lsq_req);

	// A held owner overrides priority until the line completes.
	assign owner_sel = (owner_q != pmem_pkg::OWN_NONE) ? owner_q : owner_new;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			owner_q <= pmem_pkg::OWN_NONE;
		end else if (owner_q == pmem_pkg::OWN_NONE) begin
			if (new_req && !i_line_resp)
				owner_q <= owner_new; // Lock on first request cycle.
		end else if (i_line_resp) begin
			owner_q <= pmem_pkg::OWN_NONE;
		end
	end

	always_comb begin
		o_inst_resp  = 1'b0;
		o_inst_rdata = '0;
		o_lsq_resp   = 1'b0;
		o_lsq_rdata  = '0;
		o_line_read  = 1'b0;
		o_line_write = 1'b0;
		o_line_addr  = '0;
		o_line_wdata = '0;
		case (owner_sel)
			pmem_pkg::OWN_INST: begin
				o_inst_resp  = i_line_resp;
				o_inst_rdata = i_line_rdata;
				o_line_read  = i_inst_read;
				o_line_write = i_inst_write;
				o_line_addr  = i_inst_addr;
				o_line_wdata = i_inst_wdata;
			end
			pmem_pkg::OWN_LSQ: begin
				o_lsq_resp   = i_line_resp;
				o_lsq_rdata  = i_line_rdata;
				o_line_read  = i_lsq_read;
				o_line_write = i_lsq_write;
				o_line_addr  = i_lsq_addr;
				o_line_wdata = i_lsq_wdata;
			end
			default: ;
		endcase
	end

	// ============================================================
	// Checks.
	// ============================================================

	a_line_rw_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_line_read && o_line_write));

	// Ownership must survive priority changes mid-transfer.
	a_owner_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_line_read || o_line_write) && !i_line_resp |=>
		$stable({o_line_read, o_line_write, o_line_addr}));

	// A response only goes to a client that is still asking.
	a_resp_to_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(!o_inst_resp || inst_req) && (!o_lsq_resp || lsq_req));

endmodule : pmem_arbiter

/* rtl/pmem_pkg.sv */
package pmem_pkg;

	// ============================================================
	// Bus widths.
	// ============================================================

	localparam int ADDR_W = 32;
	localparam int LINE_W = 256;
	localparam int BEAT_W = 64;

	// ============================================================
	// Burst geometry.
	// ============================================================

	localparam int BURSTS      = LINE_W / BEAT_W;    // Beats per line.
	localparam int BEAT_CNT_W  = $clog2(BURSTS);
	localparam int BEAT_BYTES  = BEAT_W / 8;
	localparam int LINE_OFFS_W = $clog2(LINE_W / 8); // Byte offset inside a line.

	// ============================================================
	// Types.
	// ============================================================

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [BEAT_W-1:0] beat_t;

	// Client currently holding the memory port.
	typedef enum logic [1:0] {
		OWN_NONE = 2'b00,
		OWN_INST = 2'b01,
		OWN_LSQ  = 2'b10
	} owner_e;

endpackage : pmem_pkg

/* rtl/pmem_subsystem.sv */
`timescale 1ns/1ns

module pmem_subsystem (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic            i_iq_empty,

	input  logic            i_inst_read,
	input  logic            i_inst_write,
	input  pmem_pkg::addr_t i_inst_addr,
	input  pmem_pkg::line_t i_inst_wdata,
	output logic            o_inst_resp,
	output pmem_pkg::line_t o_inst_rdata,

	input  logic            i_lsq_read,
	input  logic            i_lsq_write,
	input  pmem_pkg::addr_t i_lsq_addr,
	input  pmem_pkg::line_t i_lsq_wdata,
	output logic            o_lsq_resp,
	output pmem_pkg::line_t o_lsq_rdata,

	output logic            o_burst_read,
	output logic            o_burst_write,
	output pmem_pkg::addr_t o_burst_addr,
	output pmem_pkg::beat_t o_burst_wdata,
	input  logic            i_burst_resp,
	input  pmem_pkg::beat_t i_burst_rdata
);

	// Granted line transfer.
	logic            line_read;
	logic            line_write;
	pmem_pkg::addr_t line_addr;
	pmem_pkg::line_t line_wdata;
	logic            line_resp;
	pmem_pkg::line_t line_rdata;

	pmem_arbiter u_arbiter (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_iq_empty   (i_iq_empty),
		.i_inst_read  (i_inst_read),
		.i_inst_write (i_inst_write),
		.i_inst_addr  (i_inst_addr),
		.i_inst_wdata (i_inst_wdata),
		.o_inst_resp  (o_inst_resp),
		.o_inst_rdata (o_inst_rdata),
		.i_lsq_read   (i_lsq_read),
		.i_lsq_write  (i_lsq_write),
		.i_lsq_addr   (i_lsq_addr),
		.i_lsq_wdata  (i_lsq_wdata),
		.o_lsq_resp   (o_lsq_resp),
		.o_lsq_rdata  (o_lsq_rdata),
		.o_line_read  (line_read),
		.o_line_write (line_write),
		.o_line_addr  (line_addr),
		.o_line_wdata (line_wdata),
		.i_line_resp  (line_resp),
		.i_line_rdata (line_rdata)
	);

	cacheline_adaptor u_adaptor (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_line_read   (line_read),
		.i_line_write  (line_write),
		.i_line_addr   (line_addr),
		.i_line_wdata  (line_wdata),
		.o_line_resp   (line_resp),
		.o_line_rdata  (line_rdata),
		.o_burst_read  (o_burst_read),
		.o_burst_write (o_burst_write),
		.o_burst_addr  (o_burst_addr),
		.o_burst_wdata (o_burst_wdata),
		.i_burst_resp  (i_burst_resp),
		.i_burst_rdata (i_burst_rdata)
	);

endmodule : pmem_subsystem

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_pmem_subsystem \
	-f pmem_subsystem.f -o sim_pmem || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_pmem > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed" && exit 0

/* verification/burst_mem_model.sv */
`timescale 1ns/1ns

module burst_mem_model (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic            i_read,
	input  logic            i_write,
	input  pmem_pkg::addr_t i_addr,
	input  pmem_pkg::beat_t i_wdata,
	output logic            o_resp,
	output pmem_pkg::beat_t o_rdata
);

	localparam int LATENCY = 3; // Cycles from beat request to response.
	localparam logic [63:0] FILL_XOR = 64'h5A5A_0000_0000_0000;

	pmem_pkg::beat_t mem [pmem_pkg::addr_t]; // Only written beats live here.
	logic [1:0]      wait_cnt;

	// Unwritten beats follow the address.
	function automatic pmem_pkg::beat_t fill_beat(input pmem_pkg::addr_t addr);
		return {32'h0, addr} ^ FILL_XOR;
	endfunction

	always @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wait_cnt <= '0;
			o_resp   <= 1'b0;
			o_rdata  <= '0;
		end else begin
			o_resp <= 1'b0;
			// The beat after a response starts counting once the adaptor moves on.
			if ((i_read || i_write) && !o_resp) begin
				if (wait_cnt == 2'(LATENCY - 1)) begin
					wait_cnt <= '0;
					o_resp   <= 1'b1;
					if (i_write)
						mem[i_addr] = i_wdata;
					else if (mem.exists(i_addr))
						o_rdata <= mem[i_addr];
					else
						o_rdata <= fill_beat(i_addr);
				end else begin
					wait_cnt <= wait_cnt + 2'd1;
				end
			end
		end
	end

endmodule : burst_mem_model

/* verification/tb_pmem_subsystem.sv */
`timescale 1ns/1ns

module tb_pmem_subsystem;

	// About 20 cycles per line over some 30 lines.
	localparam int MAX_CYCLES   = 4000;
	localparam int RESP_TIMEOUT = 200;
	localparam logic [63:0] FILL_XOR = 64'h5A5A_0000_0000_0000;

	logic            clk;
	logic            arst_n;
	logic            iq_empty;
	logic            inst_read, inst_write, inst_resp;
	pmem_pkg::addr_t inst_addr;
	pmem_pkg::line_t inst_wdata, inst_rdata;
	logic            lsq_read, lsq_write, lsq_resp;
	pmem_pkg::addr_t lsq_addr;
	pmem_pkg::line_t lsq_wdata, lsq_rdata;
	logic            burst_read, burst_write, burst_resp;
	pmem_pkg::addr_t burst_addr;
	pmem_pkg::beat_t burst_wdata, burst_rdata;

	pmem_pkg::line_t shadow [pmem_pkg::addr_t]; // Lines written so far.
	logic [31:0]     seed = 32'h97489834;
	int              cycle_cnt = 0;

	pmem_subsystem UUT (
		.i_clk(clk), .i_arst_n(arst_n), .i_iq_empty(iq_empty),
		.i_inst_read(inst_read), .i_inst_write(inst_write), .i_inst_addr(inst_addr),
		.i_inst_wdata(inst_wdata), .o_inst_resp(inst_resp), .o_inst_rdata(inst_rdata),
		.i_lsq_read(lsq_read), .i_lsq_write(lsq_write), .i_lsq_addr(lsq_addr),
		.i_lsq_wdata(lsq_wdata), .o_lsq_resp(lsq_resp), .o_lsq_rdata(lsq_rdata),
		.o_burst_read(burst_read), .o_burst_write(burst_write), .o_burst_addr(burst_addr),
		.o_burst_wdata(burst_wdata), .i_burst_resp(burst_resp), .i_burst_rdata(burst_rdata)
	);

	burst_mem_model u_mem (
		.i_clk(clk), .i_arst_n(arst_n), .i_read(burst_read), .i_write(burst_write),
		.i_addr(burst_addr), .i_wdata(burst_wdata), .o_resp(burst_resp), .o_rdata(burst_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			fail_run("Run went past the cycle limit.");
	end

	// ============================================================
	// Helpers and checks.
	// ============================================================

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_line(input string name, input pmem_pkg::line_t got,
		input pmem_pkg::line_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic pmem_pkg::line_t rand_line();
		pmem_pkg::line_t line;
		for (int i = 0; i < 8; i++)
			line[i*32 +: 32] = lcg_next();
		return line;
	endfunction

	function automatic pmem_pkg::addr_t line_base(input pmem_pkg::addr_t addr);
		return {addr[pmem_pkg::ADDR_W-1:pmem_pkg::LINE_OFFS_W], {pmem_pkg::LINE_OFFS_W{1'b0}}};
	endfunction

	function automatic pmem_pkg::line_t expected_line(input pmem_pkg::addr_t addr);
		pmem_pkg::addr_t base;
		pmem_pkg::line_t line;
		base = line_base(addr);
		if (shadow.exists(base))
			return shadow[base];
		for (int i = 0; i < pmem_pkg::BURSTS; i++)
			line[i*pmem_pkg::BEAT_W +: pmem_pkg::BEAT_W] =
				{32'h0, base + pmem_pkg::addr_t'(i * 8)} ^ FILL_XOR;
		return line;
	endfunction

	task automatic issue(input logic to_lsq, input logic wr, input pmem_pkg::addr_t addr,
		input pmem_pkg::line_t wdata);
		if (to_lsq) begin
			lsq_read  = !wr;
			lsq_write = wr;
			lsq_addr  = addr;
			lsq_wdata = wdata;
		end else begin
			inst_read  = !wr;
			inst_write = wr;
			inst_addr  = addr;
			inst_wdata = wdata;
		end
	endtask

	// Waits for the pulse while the other client stays quiet.
	task automatic complete(input logic to_lsq, input logic wr, input pmem_pkg::addr_t addr,
		input pmem_pkg::line_t wdata);
		int              cycles;
		logic            seen;
		pmem_pkg::line_t rdata;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk);
			if (to_lsq) begin
				check_bit("o_inst_resp", inst_resp, 1'b0);
				check_line("o_inst_rdata", inst_rdata, '0);
				seen  = lsq_resp;
				rdata = lsq_rdata;
			end else begin
				check_bit("o_lsq_resp", lsq_resp, 1'b0);
				check_line("o_lsq_rdata", lsq_rdata, '0);
				seen  = inst_resp;
				rdata = inst_rdata;
			end
			cycles++;
			if (!seen && cycles >= RESP_TIMEOUT)
				fail_run("A client request got no response within the timeout.");
		end
		if (wr)
			shadow[line_base(addr)] = wdata;
		else if (to_lsq)
			check_line("o_lsq_rdata", rdata, expected_line(addr));
		else
			check_line("o_inst_rdata", rdata, expected_line(addr));
		@(posedge clk);
		#1;
		issue(to_lsq, 1'b0, '0, '0);
		if (to_lsq)
			lsq_read = 1'b0;
		else
			inst_read = 1'b0;
	endtask

	// ============================================================
	// Directed tests.
	// ============================================================

	task automatic inst_line_read();
		pmem_pkg::addr_t a;
		a = lcg_next() & 32'h0000_07FF;
		issue(1'b0, 1'b0, a, '0);
		complete(1'b0, 1'b0, a, '0);
	endtask

	task automatic lsq_write_then_read();
		pmem_pkg::addr_t a;
		pmem_pkg::line_t d;
		a = lcg_next() & 32'h0000_07FF;
		d = rand_line();
		issue(1'b1, 1'b1, a, d);
		complete(1'b1, 1'b1, a, d);
		issue(1'b1, 1'b0, a, '0);
		complete(1'b1, 1'b0, a, '0);
	endtask

	task automatic lsq_beats_inst();
		pmem_pkg::addr_t ai, al;
		ai = lcg_next() & 32'h0000_07FF;
		al = lcg_next() & 32'h0000_07FF;
		issue(1'b0, 1'b0, ai, '0);
		issue(1'b1, 1'b0, al, '0);
		complete(1'b1, 1'b0, al, '0);
		complete(1'b0, 1'b0, ai, '0);
	endtask

	task automatic iq_empty_forces_inst();
		pmem_pkg::addr_t ai, al;
		ai = lcg_next() & 32'h0000_07FF;
		al = lcg_next() & 32'h0000_07FF;
		iq_empty = 1'b1;
		issue(1'b1, 1'b0, al, '0);
		issue(1'b0, 1'b0, ai, '0);
		complete(1'b0, 1'b0, ai, '0);
		iq_empty = 1'b0; // Lsq can only win again once the queue refills.
		complete(1'b1, 1'b0, al, '0);
	endtask

	task automatic owner_lock_mid_burst();
		pmem_pkg::addr_t a;
		pmem_pkg::line_t d;
		a = lcg_next() & 32'h0000_07FF;
		d = rand_line();
		issue(1'b1, 1'b1, a, d);
		repeat (3) @(posedge clk);
		#1;
		iq_empty = 1'b1; // Mid burst.
		issue(1'b0, 1'b0, a, '0);
		complete(1'b1, 1'b1, a, d);
		complete(1'b0, 1'b0, a, '0);
		iq_empty = 1'b0;
	endtask

	task automatic random_traffic();
		logic [31:0]     r;
		pmem_pkg::addr_t a;
		pmem_pkg::line_t d;
		for (int n = 0; n < 20; n++) begin
			r = lcg_next();
			a = lcg_next() & 32'h0000_07FF;
			d = rand_line();
			issue(r[4], r[9], a, d);
			complete(r[4], r[9], a, d);
		end
	endtask

	initial begin
		arst_n   = 1'b0;
		iq_empty = 1'b0;
		issue(1'b0, 1'b0, '0, '0);
		issue(1'b1, 1'b0, '0, '0);
		inst_read = 1'b0;
		lsq_read  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		check_bit("o_inst_resp", inst_resp, 1'b0);
		check_bit("o_lsq_resp", lsq_resp, 1'b0);
		check_bit("o_burst_read", burst_read, 1'b0);
		check_bit("o_burst_write", burst_write, 1'b0);
		inst_line_read();
		lsq_write_then_read();
		lsq_beats_inst();
		iq_empty_forces_inst();
		owner_lock_mid_burst();
		random_traffic();
		$display("No errors");
		$finish;
	end

endmodule : tb_pmem_subsystem
